/* sim/msix_cases.txt */
// op (0 idle, 1 write, 2 read, f end)  address  write data  byte enables  pba  count
// expected read data, checked on reads only
2 3008 0 0 0 0 0000000100000000
2 3070 0 0 0 0 0
1 3000 1122334455667788 ff 0 0 0
1 3078 a5a5a5a55a5a5a5a ff 0 0 0
1 3030 0123456789abcdef ff 0 0 0
1 3058 fedcba9876543210 ff 0 0 0
2 3000 0 0 0 0 1122334455667788
2 3078 0 0 0 0 a5a5a5a55a5a5a5a
2 3030 0 0 0 0 0123456789abcdef
2 3058 0 0 0 0 fedcba9876543210
1 3000 00000000deadbeef 0f 0 0 0
1 3004 00000000cafef00d f0 0 0 0
1 301c 0000000012345678 f0 0 0 0
2 3000 0 0 0 0 cafef00ddeadbeef
2 3018 0 0 0 0 1234567800000000
1 2000 ffffffffffffffff ff 55 0 0
1 2008 00000000ffffffff ff 2a 01020304 0
2 2000 0 0 7f a0b0c0d0 000000000000002a
2 2008 0 0 0 0 00000000a0b0c0d0
2 4000 0 0 0 0 0
2 3080 0 0 0 0 0
f 0 0 0 0 0 0

/* verilog.f */
design/msix_map_pkg.sv
design/msix_reg_pkg.sv
design/msix_write_decode.sv
design/msix_table_regs.sv
design/msix_read_port.sv
design/msix_csr_top.sv
sim/tb_msix_csr.sv

/* run_sim.sh */
#!/usr/bin/env bash
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert --timescale 1ns/1ps \
   -f verilog.f --top-module tb_msix_csr -o tb_msix_csr

out=$(./obj_dir/tb_msix_csr)
echo "$out"
echo "$out" | grep -qx "ALL TESTS PASSED"

/* sim/tb_msix_csr.sv */
// MSI-X CSR testbench

`timescale 1ns/1ps

module tb_msix_csr;

   localparam int MAX_CASES = 32;
   localparam int FIELDS    = 7;
   localparam int NV        = msix_map_pkg::NUM_VECTORS;
   localparam int AW        = msix_map_pkg::ADDR_W;

   logic                                clk;
   logic                                rst_n;
   logic                                write;
   logic                                read;
   logic [AW-1:0]                       address;
   logic [msix_map_pkg::DATA_W-1:0]     writedata;
   logic [msix_map_pkg::BE_W-1:0]       byteenable;
   logic [msix_map_pkg::DATA_W-1:0]     readdata;
   logic                                readdatavalid;
   logic                                writeresponsevalid;
   logic [msix_map_pkg::PBA_W-1:0]      msix_pba_in;
   logic [msix_map_pkg::COUNT_W-1:0]    msix_count_in;
   msix_reg_pkg::table_word_t [NV-1:0]  msix_addr;
   msix_reg_pkg::table_word_t [NV-1:0]  msix_ctldat;
   logic [msix_map_pkg::DATA_W-1:0]     msix_pba;

   logic [63:0] case_mem [MAX_CASES*FIELDS];
   int          case_err [MAX_CASES];
   int          num_cases;
   int          errors;
   int          cycles;
   int          cycle_limit;

   // Reference model of the register contents
   logic [63:0] m_addr [NV];
   logic [63:0] m_ctl [NV];
   logic [63:0] m_pba;
   logic [63:0] m_count;

   msix_csr_top uut (.*);

   initial
   begin
      clk = 1'b0;
      forever #50 clk = ~clk;
   end

   // Columns 0 op, 1 address, 2 write data, 3 byte enables, 4 pba, 5 count, 6 expected read
   function automatic logic [63:0] field(input int idx, input int col);
      if (idx < 0)
         return 64'd0;
      return case_mem[idx*FIELDS + col];
   endfunction

   task automatic record_failure(input int idx);
      errors++;
      if (idx >= 0)
         case_err[idx]++;
   endtask

   // Table slot is the byte offset over 8, or -1 outside the table
   function automatic int table_slot(input logic [AW-1:0] addr);
      logic [AW-1:0] off;
      off = addr - msix_map_pkg::TABLE_BASE;
      if (off < AW'(NV * msix_map_pkg::ENTRY_STRIDE))
         return int'(off[AW-1:3]);
      return -1;
   endfunction

   task automatic model_write(input int idx);
      int            slot;
      logic [63:0]   word;
      logic [63:0]   data;
      logic [AW-1:0] addr;
      addr = AW'(field(idx, 1));
      data = field(idx, 2);
      slot = table_slot(addr);
      if (slot < 0)
         return;
      word = slot[0] ? m_ctl[slot/2] : m_addr[slot/2];
      // Half writes take the low half of the bus
      if (field(idx, 3) == 64'hff)
         word = data;
      else if (!addr[2])
         word[31:0] = data[31:0];
      else
         word[63:32] = data[31:0];
      if (slot[0])
         m_ctl[slot/2] = word;
      else
         m_addr[slot/2] = word;
   endtask

   function automatic logic [63:0] model_read(input logic [AW-1:0] addr);
      int slot;
      slot = table_slot(addr);
      if (slot >= 0)
         return slot[0] ? m_ctl[slot/2] : m_addr[slot/2];
      if (addr[AW-1:3] == msix_map_pkg::PBA_ADDR[AW-1:3])
         return m_pba;
      if (addr[AW-1:3] == msix_map_pkg::COUNT_ADDR[AW-1:3])
         return m_count;
      return 64'd0;
   endfunction

   // Index -1 drives an idle bus with zero status inputs
   task automatic drive_case(input int idx);
      write         = field(idx, 0) == 64'd1;
      read          = field(idx, 0) == 64'd2;
      address       = AW'(field(idx, 1));
      writedata     = field(idx, 2);
      byteenable    = msix_map_pkg::BE_W'(field(idx, 3));
      msix_pba_in   = msix_map_pkg::PBA_W'(field(idx, 4));
      msix_count_in = msix_map_pkg::COUNT_W'(field(idx, 5));
   endtask

   // ----------------------------------------------------------------------
   // Main sequence, one case per cycle
   // ----------------------------------------------------------------------
   initial
   begin
      int h1;
      int h2;
      int passed;
      rst_n  = 1'b0;
      errors = 0;
      drive_case(-1);
      $readmemh("sim/msix_cases.txt", case_mem);
      num_cases = 0;
      while (num_cases < MAX_CASES && case_mem[num_cases*FIELDS] != 64'hf)
         num_cases++;
      cycle_limit = 4 * num_cases + 20;
      if (num_cases == 0)
      begin
         $display("No cases found in sim/msix_cases.txt");
         errors++;
      end
      for (int v = 0; v < NV; v++)
      begin
         m_addr[v] = 64'd0;
         m_ctl[v]  = msix_reg_pkg::CTLDAT_RESET;
      end
      m_pba   = 64'd0;
      m_count = 64'd0;
      h1 = -1;
      h2 = -1;
      repeat (3) @(posedge clk);
      #1;
      rst_n = 1'b1;
      for (int c = 0; c < num_cases + 2; c++)
      begin
         @(posedge clk);
         #1;
         // Read issued last cycle answers now
         if (readdatavalid !== (field(h1, 0) == 64'd2))
         begin
            $display("[FAIL] case %0d readdatavalid: got %h expected %h",
                     h1, readdatavalid, field(h1, 0) == 64'd2);
            record_failure(h1);
         end
         else if (readdatavalid && readdata !== field(h1, 6))
         begin
            $display("[FAIL] case %0d readdata: got %h expected %h", h1, readdata, field(h1, 6));
            record_failure(h1);
         end
         if (writeresponsevalid !== (field(h2, 0) == 64'd1))
         begin
            $display("[FAIL] case %0d writeresponsevalid: got %h expected %h",
                     h2, writeresponsevalid, field(h2, 0) == 64'd1);
            record_failure(h2);
         end
         // Write from two cycles back lands, status words follow last cycle's inputs
         if (field(h2, 0) == 64'd1)
            model_write(h2);
         m_pba   = field(h1, 4) & ((64'd1 << msix_map_pkg::PBA_W) - 64'd1);
         m_count = field(h1, 5) & ((64'd1 << msix_map_pkg::COUNT_W) - 64'd1);
         for (int v = 0; v < NV; v++)
         begin
            if (msix_addr[v] !== m_addr[v])
            begin
               $display("[FAIL] case %0d msix_addr[%0d]: got %h expected %h",
                        h2, v, msix_addr[v], m_addr[v]);
               record_failure(h2);
            end
            if (msix_ctldat[v] !== m_ctl[v])
            begin
               $display("[FAIL] case %0d msix_ctldat[%0d]: got %h expected %h",
                        h2, v, msix_ctldat[v], m_ctl[v]);
               record_failure(h2);
            end
         end
         if (msix_pba !== m_pba)
         begin
            $display("[FAIL] case %0d msix_pba: got %h expected %h", h1, msix_pba, m_pba);
            record_failure(h1);
         end
         if (h2 >= 0)
            $display("case %0d op %0h addr %h: %s", h2, field(h2, 0), AW'(field(h2, 1)),
                     case_err[h2] == 0 ? "passed" : "failed");
         h2 = h1;
         h1 = (c < num_cases) ? c : -1;
         drive_case(h1);
         if (field(h1, 0) == 64'd2 && model_read(address) !== field(h1, 6))
         begin
            $display("Case %0d: the case file expects %h but the reference model gives %h",
                     h1, field(h1, 6), model_read(address));
            record_failure(h1);
         end
      end
      passed = 0;
      for (int i = 0; i < num_cases; i++)
         if (case_err[i] == 0)
            passed++;
      $display("%0d cases, %0d passed, %0d failed, %0d errors",
               num_cases, passed, num_cases - passed, errors);
      if (errors == 0)
         $display("ALL TESTS PASSED");
      else
         $display("SOME TESTS FAILED");
      $finish;
   end

   // Watchdog on the total cycle count
   initial
   begin
      cycles = 0;
      wait (cycle_limit != 0);
      while (cycles < cycle_limit)
      begin
         @(posedge clk);
         cycles++;
      end
      $display("Timeout: the run did not finish within %0d cycles", cycle_limit);
      $display("SOME TESTS FAILED");
      $finish;
   end

endmodule

/* design/msix_csr_top.sv */
// MSI-X CSR block top level

`timescale 1ns/1ps

module msix_csr_top (
   input  logic                                                clk,
   input  logic                                                rst_n,
   input  logic                                                write,
   input  logic                                                read,
   input  logic [msix_map_pkg::ADDR_W-1:0]                     address,
   input  logic [msix_map_pkg::DATA_W-1:0]                     writedata,
   input  logic [msix_map_pkg::BE_W-1:0]                       byteenable,
   output logic [msix_map_pkg::DATA_W-1:0]                     readdata,
   output logic                                                readdatavalid,
   output logic                                                writeresponsevalid,
   input  logic [msix_map_pkg::PBA_W-1:0]                      msix_pba_in,
   input  logic [msix_map_pkg::COUNT_W-1:0]                    msix_count_in,
   output msix_reg_pkg::table_word_t [msix_map_pkg::NUM_VECTORS-1:0] msix_addr,
   output msix_reg_pkg::table_word_t [msix_map_pkg::NUM_VECTORS-1:0] msix_ctldat,
   output logic [msix_map_pkg::DATA_W-1:0]                     msix_pba
);

   msix_reg_pkg::write_kind_t                                  wr_kind;
   logic [msix_map_pkg::DATA_W-1:0]                            wr_data;
   logic [msix_map_pkg::NUM_REGS-1:0]                          wr_sel;
   logic                                                       wr_pulse;
   logic [msix_map_pkg::NUM_REGS-1:0][msix_map_pkg::DATA_W-1:0] reg_words;

   msix_write_decode u_write_decode (
      .clk        (clk),
      .rst_n      (rst_n),
      .write      (write),
      .address    (address),
      .writedata  (writedata),
      .byteenable (byteenable),
      .wr_kind    (wr_kind),
      .wr_data    (wr_data),
      .wr_sel     (wr_sel),
      .wr_pulse   (wr_pulse)
   );

   msix_table_regs u_table_regs (
      .clk           (clk),
      .rst_n         (rst_n),
      .wr_kind       (wr_kind),
      .wr_data       (wr_data),
      .wr_sel        (wr_sel),
      .msix_pba_in   (msix_pba_in),
      .msix_count_in (msix_count_in),
      .reg_words     (reg_words),
      .msix_addr     (msix_addr),
      .msix_ctldat   (msix_ctldat),
      .msix_pba      (msix_pba)
   );

   msix_read_port u_read_port (
      .clk                (clk),
      .rst_n              (rst_n),
      .read               (read),
      .address            (address),
      .wr_pulse           (wr_pulse),
      .reg_words          (reg_words),
      .readdata           (readdata),
      .readdatavalid      (readdatavalid),
      .writeresponsevalid (writeresponsevalid)
   );

endmodule

/* design/msix_read_port.sv */
// MSI-X read and response port

`timescale 1ns/1ps

module msix_read_port (
   input  logic                                                  clk,
   input  logic                                                  rst_n,
   input  logic                                                  read,
   input  logic [msix_map_pkg::ADDR_W-1:0]                       address,
   input  logic                                                  wr_pulse,
   input  logic [msix_map_pkg::NUM_REGS-1:0][msix_map_pkg::DATA_W-1:0] reg_words,
   output logic [msix_map_pkg::DATA_W-1:0]                       readdata,
   output logic                                                  readdatavalid,
   output logic                                                  writeresponsevalid
);

   logic [msix_map_pkg::NUM_REGS-1:0]      rd_sel;
   logic [msix_map_pkg::DATA_W-1:0]        rd_word;

   assign rd_sel = msix_map_pkg::decode_addr(address);

   // One-hot OR mux, unmapped addresses fall through to zero
   always_comb
   begin
      rd_word = '0;
      for (int s = 0; s < msix_map_pkg::NUM_REGS; s++)
         if (rd_sel[s])
            rd_word = rd_word | reg_words[s];
   end

   always_ff @(posedge clk)
   begin
      readdata <= rd_word;
   end

   always_ff @(posedge clk)
   begin
      if (!rst_n)
      begin
         readdatavalid      <= 1'b0;
         writeresponsevalid <= 1'b0;
      end
      else
      begin
         readdatavalid      <= read;
         writeresponsevalid <= wr_pulse;
      end
   end

   a_rdvalid: assert property (@(posedge clk) disable iff (!rst_n)
      readdatavalid |-> $past(read));

endmodule

/* design/msix_table_regs.sv */
// MSI-X vector table store

`timescale 1ns/1ps

module msix_table_regs (
   input  logic                                                  clk,
   input  logic                                                  rst_n,
   input  msix_reg_pkg::write_kind_t                             wr_kind,
   input  logic [msix_map_pkg::DATA_W-1:0]                       wr_data,
   input  logic [msix_map_pkg::NUM_REGS-1:0]                     wr_sel,
   input  logic [msix_map_pkg::PBA_W-1:0]                        msix_pba_in,
   input  logic [msix_map_pkg::COUNT_W-1:0]                      msix_count_in,
   output logic [msix_map_pkg::NUM_REGS-1:0][msix_map_pkg::DATA_W-1:0] reg_words,
   output msix_reg_pkg::table_word_t [msix_map_pkg::NUM_VECTORS-1:0]   msix_addr,
   output msix_reg_pkg::table_word_t [msix_map_pkg::NUM_VECTORS-1:0]   msix_ctldat,
   output logic [msix_map_pkg::DATA_W-1:0]                       msix_pba
);

   localparam int NUM_SLOTS = 2 * msix_map_pkg::NUM_VECTORS;
   localparam int HALF_W    = msix_reg_pkg::HALF_W;

   msix_reg_pkg::table_word_t               slot_q [NUM_SLOTS];
   logic [msix_map_pkg::DATA_W-1:0]         pba_q;
   logic [msix_map_pkg::DATA_W-1:0]         count_q;

   // ----------------------------------------------------------------------
   // Table slots
   // ----------------------------------------------------------------------
   for (genvar i = 0; i < NUM_SLOTS; i++)
   begin : g_slot
      localparam bit IS_CTLDAT = (i % 2) == 1;

      msix_reg_pkg::table_word_t nxt;

      // Half-word writes always take the low half of the bus
      always_comb
      begin
         nxt = slot_q[i];
         if (wr_sel[i])
         begin
            case (wr_kind)
               msix_reg_pkg::FULL64:
                  nxt = wr_data;
               msix_reg_pkg::LOWER32:
                  if (IS_CTLDAT)
                     nxt.ctldat.msg_data = wr_data[HALF_W-1:0];
                  else
                     nxt.addr.addr_lo = wr_data[HALF_W-1:0];
               msix_reg_pkg::UPPER32:
                  if (IS_CTLDAT)
                     nxt.ctldat.msg_control = wr_data[HALF_W-1:0];
                  else
                     nxt.addr.addr_hi = wr_data[HALF_W-1:0];
               default:
                  nxt = slot_q[i];
            endcase
         end
      end

      always_ff @(posedge clk)
      begin
         if (!rst_n)
         begin
            if (IS_CTLDAT)
               slot_q[i] <= msix_reg_pkg::CTLDAT_RESET;
            else
            begin
               slot_q[i].addr.addr_hi <= '0;
               slot_q[i].addr.addr_lo <= '0;
            end
         end
         else
            slot_q[i] <= nxt;
      end
   end

   // ----------------------------------------------------------------------
   // Status words
   // ----------------------------------------------------------------------
   // Status words follow their inputs and ignore bus writes
   always_ff @(posedge clk)
   begin
      pba_q   <= {{(msix_map_pkg::DATA_W - msix_map_pkg::PBA_W){1'b0}}, msix_pba_in};
      count_q <= {{(msix_map_pkg::DATA_W - msix_map_pkg::COUNT_W){1'b0}}, msix_count_in};
   end

   always_comb
   begin
      for (int v = 0; v < msix_map_pkg::NUM_VECTORS; v++)
      begin
         msix_addr[v]   = slot_q[2*v];
         msix_ctldat[v] = slot_q[2*v+1];
      end
      for (int s = 0; s < NUM_SLOTS; s++)
         reg_words[s] = slot_q[s];
      reg_words[msix_map_pkg::SEL_PBA]   = pba_q;
      reg_words[msix_map_pkg::SEL_COUNT] = count_q;
   end

   assign msix_pba = pba_q;

   // Writes aimed at status slots leave the sampled inputs in place
   a_pba_ro: assert property (@(posedge clk) disable iff (!rst_n)
      wr_sel[msix_map_pkg::SEL_PBA] |=>
         pba_q == msix_map_pkg::DATA_W'($past(msix_pba_in)));

   a_count_ro: assert property (@(posedge clk) disable iff (!rst_n)
      wr_sel[msix_map_pkg::SEL_COUNT] |=>
         count_q == msix_map_pkg::DATA_W'($past(msix_count_in)));

endmodule

/* design/msix_write_decode.sv */
// MSI-X write decoder

`timescale 1ns/1ps

module msix_write_decode (
   input  logic                                  clk,
   input  logic                                  rst_n,
   input  logic                                  write,
   input  logic [msix_map_pkg::ADDR_W-1:0]       address,
   input  logic [msix_map_pkg::DATA_W-1:0]       writedata,
   input  logic [msix_map_pkg::BE_W-1:0]         byteenable,
   output msix_reg_pkg::write_kind_t             wr_kind,
   output logic [msix_map_pkg::DATA_W-1:0]       wr_data,
   output logic [msix_map_pkg::NUM_REGS-1:0]     wr_sel,
   output logic                                  wr_pulse
);

   msix_reg_pkg::write_kind_t              kind_next;
   logic [msix_map_pkg::NUM_REGS-1:0]      sel_next;

   // ----------------------------------------------------------------------
   // Classify the write
   // ----------------------------------------------------------------------
   // All lanes enabled is a full word, otherwise address bit 2 picks the half
   always_comb
   begin
      if (!write)
         kind_next = msix_reg_pkg::NONE;
      else if (&byteenable)
         kind_next = msix_reg_pkg::FULL64;
      else if (!address[2])
         kind_next = msix_reg_pkg::LOWER32;
      else
         kind_next = msix_reg_pkg::UPPER32;
   end

   assign sel_next = write ? msix_map_pkg::decode_addr(address) : '0;

   always_ff @(posedge clk)
   begin
      if (!rst_n)
      begin
         wr_kind  <= msix_reg_pkg::NONE;
         wr_sel   <= '0;
         wr_pulse <= 1'b0;
      end
      else
      begin
         wr_kind  <= kind_next;
         wr_sel   <= sel_next;
         wr_pulse <= write;
      end
   end

   // Write data travels with the kind and select
   always_ff @(posedge clk)
   begin
      wr_data <= writedata;
   end

   // At most one slot selected, and only on a write cycle
   a_sel_onehot: assert property (@(posedge clk) disable iff (!rst_n)
      $onehot0(wr_sel) && (wr_pulse || wr_sel == '0));

endmodule

/* design/msix_reg_pkg.sv */
// MSI-X register layout

package msix_reg_pkg;

   localparam int HALF_W = 32;

   // Kind of write applied to a 64-bit table register
   typedef enum logic [1:0] {
      NONE    = 2'd0,
      LOWER32 = 2'd1,
      UPPER32 = 2'd2,
      FULL64  = 2'd3
   } write_kind_t;

   // ----------------------------------------------------------------------
   // Table word views
   // ----------------------------------------------------------------------

   // Even slots, the message address
   typedef struct packed {
      logic [HALF_W-1:0] addr_hi;
      logic [HALF_W-1:0] addr_lo;
   } addr_view_t;

   // Odd slots, vector control over message data
   // Bit 0 of msg_control is the vector mask
   typedef struct packed {
      logic [HALF_W-1:0] msg_control;
      logic [HALF_W-1:0] msg_data;
   } ctldat_view_t;

   typedef union packed {
      addr_view_t   addr;
      ctldat_view_t ctldat;
   } table_word_t;

   // Vectors come out of reset masked
   localparam logic [2*HALF_W-1:0] CTLDAT_RESET = 64'h0000_0001_0000_0000;

endpackage

/* design/msix_map_pkg.sv */
// MSI-X address map

package msix_map_pkg;

   // Bus widths
   localparam int ADDR_W = 20;
   localparam int DATA_W = 64;
   localparam int BE_W   = 8;

   // Vector table and status word sizes
   localparam int NUM_VECTORS  = 8;
   localparam int PBA_W        = 7;
   localparam int COUNT_W      = 32;
   localparam int ENTRY_STRIDE = 16;

   // ----------------------------------------------------------------------
   // Byte addresses
   // ----------------------------------------------------------------------
   localparam logic [ADDR_W-1:0] TABLE_BASE = 20'h0_3000;
   localparam logic [ADDR_W-1:0] PBA_ADDR   = 20'h0_2000;
   localparam logic [ADDR_W-1:0] COUNT_ADDR = 20'h0_2008;

   // Slots 0..15 alternate address and control/data words per vector
   localparam int NUM_REGS  = 18;
   localparam int SEL_PBA   = 16;
   localparam int SEL_COUNT = 17;

   // Table spans 128 bytes, so bits above this index select the region
   localparam int TABLE_SPAN_W = $clog2(NUM_VECTORS * ENTRY_STRIDE);

   // One-hot slot select for a bus address, zero when unmapped
   function automatic logic [NUM_REGS-1:0] decode_addr(input logic [ADDR_W-1:0] addr);
      logic [NUM_REGS-1:0] sel;
      sel = '0;
      if (addr[ADDR_W-1:TABLE_SPAN_W] == TABLE_BASE[ADDR_W-1:TABLE_SPAN_W])
         sel[addr[TABLE_SPAN_W-1:3]] = 1'b1;
      else if (addr[ADDR_W-1:3] == PBA_ADDR[ADDR_W-1:3])
         sel[SEL_PBA] = 1'b1;
      else if (addr[ADDR_W-1:3] == COUNT_ADDR[ADDR_W-1:3])
         sel[SEL_COUNT] = 1'b1;
      return sel;
   endfunction

endpackage
